// ==== hdl/avl_bus_pkg.sv ====
package avl_bus_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Longest burst a master may issue
  localparam int BURST_MAX_COUNT = 8;

  // Burst count field must hold BURST_MAX_COUNT itself
  localparam int BURST_CNT_W = $clog2(BURST_MAX_COUNT) + 1;

  // Upper bound on masters sharing the slave
  localparam int MASTER_MAX = 16;

  // Outstanding reads tracked by the response router
  localparam int RSP_FIFO_DEPTH = 16;

  // One master command as seen on the bus
  // Fields follow the slave port order
  typedef struct packed {
    // Target address
    logic [ADDR_W-1:0]      address;
    // Write payload, ignored on reads
    logic [DATA_W-1:0]      writedata;
    // Read strobe
    logic                   read;
    // Write strobe
    logic                   write;
    // Beats in this burst, valid on first beat
    logic [BURST_CNT_W-1:0] burst_count;
    // High only on the first beat of a burst
    logic                   begin_burst_transfer;
  } avl_cmd_t;

endpackage

// ==== hdl/avl_bus_priority_encoder.sv ====
`timescale 1ns/1ps

module avl_bus_priority_encoder #(
  parameter int SIGN_WIDTH = 8
) (
  input  logic [SIGN_WIDTH-1:0]         in,
  output logic [$clog2(SIGN_WIDTH)-1:0] out,
  output logic                          valid
);

  localparam int IDX_W = $clog2(SIGN_WIDTH);

  // Lowest set bit wins
  // Scan from the top so the last hit is the lowest index
  always_comb begin
    out = '0;
    for (int i = SIGN_WIDTH - 1; i >= 0; i--) begin
      if (in[i]) begin
        out = IDX_W'(i);
      end
    end
  end

  // Any request at all
  assign valid = |in;

endmodule

// ==== hdl/avl_bus_mux_n21.sv ====
`timescale 1ns/1ps

module avl_bus_mux_n21 #(
  parameter int  NUM       = 4,
  parameter type PAYLOAD_T = logic [7:0]
) (
  input  logic [$clog2(NUM)-1:0] sel,
  input  PAYLOAD_T               in [NUM],
  output PAYLOAD_T               out
);

  // Out-of-range index falls back to entry 0
  // Only reachable when NUM is not a power of two
  always_comb begin
    if (int'(sel) < NUM) begin
      out = in[sel];
    end else begin
      out = in[0];
    end
  end

endmodule

// ==== hdl/avl_bus_nm21_arb.sv ====
`timescale 1ns/1ps

module avl_bus_nm21_arb #(
  // 0 round robin, 1 fixed priority
  parameter int ARB_METHOD = 0,
  parameter int MASTER_NUM = 4
) (
  input  logic                          clk,
  input  logic                          rest,
  input  logic [MASTER_NUM-1:0]         request,
  input  avl_bus_pkg::avl_cmd_t         avl_m_cmd,
  input  logic                          avl_m_ready,
  output logic [$clog2(MASTER_NUM)-1:0] sel
);

  localparam int SEL_W = $clog2(MASTER_NUM);

  typedef logic [MASTER_NUM-1:0] req_vec_t;

  // Remaining beats of a locked burst
  logic [avl_bus_pkg::BURST_CNT_W-1:0] lock_cnt;
  logic [SEL_W-1:0]                    lock_sel;
  // Master accepted most recently
  logic [SEL_W-1:0]                    last_sel;
  // Grant when no burst is in progress
  logic [SEL_W-1:0]                    now_sel;
  // Winner in real master numbering, before the idle fallback
  logic [SEL_W-1:0]                    base_sel;
  req_vec_t                            enc_in;
  logic [SEL_W-1:0]                    enc_out;
  logic                                enc_valid;
  logic                                accept;

  // Beat handed to the slave this cycle
  assign accept = avl_m_ready && (avl_m_cmd.read || avl_m_cmd.write);

  // Nobody asking, so park on the last grant
  assign now_sel = enc_valid ? base_sel : last_sel;

  // Burst lock overrides arbitration
  assign sel = (lock_cnt != '0) ? lock_sel : now_sel;

  generate
    if (ARB_METHOD == 0) begin : g_rr
      req_vec_t       rot [MASTER_NUM];
      logic [SEL_W:0] sum;

      // rot[k] bit 0 is the master right after k
      for (genvar k = 0; k < MASTER_NUM; k++) begin : g_rot
        for (genvar j = 0; j < MASTER_NUM; j++) begin : g_bit
          assign rot[k][j] = request[(k + 1 + j) % MASTER_NUM];
        end
      end

      // Pick the rotation that starts after the last grant
      avl_bus_mux_n21 #(
        .NUM      (MASTER_NUM),
        .PAYLOAD_T(req_vec_t)
      ) rot_mux_inst (
        .sel(last_sel),
        .in (rot),
        .out(enc_in)
      );

      // Undo the rotation, sum stays below 2*MASTER_NUM
      assign sum = {1'b0, last_sel} + {1'b0, enc_out} + (SEL_W + 1)'(1);
      assign base_sel = (int'(sum) >= MASTER_NUM) ? SEL_W'(int'(sum) - MASTER_NUM)
                                                  : sum[SEL_W-1:0];
    end else begin : g_prio
      // Lowest index always wins
      assign enc_in   = request;
      assign base_sel = enc_out;
    end
  endgenerate

  avl_bus_priority_encoder #(
    .SIGN_WIDTH(MASTER_NUM)
  ) enc_inst (
    .in   (enc_in),
    .out  (enc_out),
    .valid(enc_valid)
  );

  // Burst lock, loaded on an accepted first beat
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      lock_cnt <= '0;
      lock_sel <= '0;
    end else if (accept) begin
      if (lock_cnt != '0) begin
        lock_cnt <= lock_cnt - 1'b1;
      end else if (avl_m_cmd.begin_burst_transfer && avl_m_cmd.burst_count != '0) begin
        // First beat already counts
        lock_cnt <= avl_m_cmd.burst_count - 1'b1;
        lock_sel <= sel;
      end
    end
  end

  // Master 0 goes first after reset
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      last_sel <= SEL_W'(MASTER_NUM - 1);
    end else if (accept) begin
      last_sel <= sel;
    end
  end

endmodule

// ==== hdl/avl_bus_rsp_route.sv ====
`timescale 1ns/1ps

module avl_bus_rsp_route #(
  parameter int MASTER_NUM = 4
) (
  input  logic                          clk,
  input  logic                          rest,
  input  logic                          push,
  input  logic [$clog2(MASTER_NUM)-1:0] owner,
  input  logic                          pop,
  output logic                          full,
  output logic [MASTER_NUM-1:0]         readdatavalid_out
);

  localparam int OWN_W   = $clog2(MASTER_NUM);
  localparam int DEPTH   = avl_bus_pkg::RSP_FIFO_DEPTH;
  localparam int PTR_W   = $clog2(DEPTH);
  localparam int COUNT_W = PTR_W + 1;

  // Issuer of each outstanding read, oldest at rd_ptr
  logic [OWN_W-1:0]   owner_mem [DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] count;
  logic               do_push;
  logic               do_pop;

  assign full = (count == COUNT_W'(DEPTH));

  // Drop a push into a full FIFO
  assign do_push = push && !full;
  // Stray return with nothing outstanding is ignored
  assign do_pop  = pop && (count != '0);

  // Owner storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      owner_mem[wr_ptr] <= owner;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the level alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // One-hot strobe to the master at the head
  always_comb begin
    readdatavalid_out = '0;
    if (do_pop) begin
      readdatavalid_out[owner_mem[rd_ptr]] = 1'b1;
    end
  end

endmodule

// ==== hdl/avl_bus_nm21.sv ====
`timescale 1ns/1ps

module avl_bus_nm21 #(
  parameter int ARB_METHOD = 0,
  parameter int MASTER_NUM = 4
) (
  input  logic                                                clk,
  input  logic                                                rest,
  // Master side
  input  logic [MASTER_NUM-1:0]                               m_request,
  input  logic [MASTER_NUM-1:0][avl_bus_pkg::ADDR_W-1:0]      m_address,
  input  logic [MASTER_NUM-1:0][avl_bus_pkg::DATA_W-1:0]      m_writedata,
  input  logic [MASTER_NUM-1:0]                               m_read,
  input  logic [MASTER_NUM-1:0]                               m_write,
  input  logic [MASTER_NUM-1:0][avl_bus_pkg::BURST_CNT_W-1:0] m_burstcount,
  input  logic [MASTER_NUM-1:0]                               m_begin_burst,
  output logic [MASTER_NUM-1:0]                               m_ready,
  output logic [avl_bus_pkg::DATA_W-1:0]                      m_readdata,
  output logic [MASTER_NUM-1:0]                               m_readdatavalid,
  // Slave side
  output logic [avl_bus_pkg::ADDR_W-1:0]                      s_address,
  output logic [avl_bus_pkg::DATA_W-1:0]                      s_writedata,
  output logic                                                s_read,
  output logic                                                s_write,
  output logic [avl_bus_pkg::BURST_CNT_W-1:0]                 s_burstcount,
  output logic                                                s_begin_burst,
  input  logic                                                s_ready,
  input  logic [avl_bus_pkg::DATA_W-1:0]                      s_readdata,
  input  logic                                                s_readdatavalid
);

  localparam int SEL_W = $clog2(MASTER_NUM);

  // Master count out of range
  if (MASTER_NUM < 2 || MASTER_NUM > avl_bus_pkg::MASTER_MAX) begin : g_cfg_check
    $error("avl_bus_nm21: MASTER_NUM out of range");
  end

  avl_bus_pkg::avl_cmd_t m_cmd [MASTER_NUM];
  avl_bus_pkg::avl_cmd_t grant_cmd;
  logic [SEL_W-1:0]      sel;
  logic                  rsp_full;
  logic                  read_stall;
  logic                  bus_ready;

  // Pack each master's loose ports into one command
  for (genvar i = 0; i < MASTER_NUM; i++) begin : g_pack
    assign m_cmd[i].address              = m_address[i];
    assign m_cmd[i].writedata            = m_writedata[i];
    assign m_cmd[i].read                 = m_read[i];
    assign m_cmd[i].write                = m_write[i];
    assign m_cmd[i].burst_count          = m_burstcount[i];
    assign m_cmd[i].begin_burst_transfer = m_begin_burst[i];
    // Only the granted master sees ready
    assign m_ready[i] = (sel == SEL_W'(i)) ? bus_ready : 1'b0;
  end

  avl_bus_nm21_arb #(
    .ARB_METHOD(ARB_METHOD),
    .MASTER_NUM(MASTER_NUM)
  ) arb_inst (
    .clk        (clk),
    .rest       (rest),
    .request    (m_request),
    .avl_m_cmd  (grant_cmd),
    .avl_m_ready(bus_ready),
    .sel        (sel)
  );

  avl_bus_mux_n21 #(
    .NUM      (MASTER_NUM),
    .PAYLOAD_T(avl_bus_pkg::avl_cmd_t)
  ) cmd_mux_inst (
    .sel(sel),
    .in (m_cmd),
    .out(grant_cmd)
  );

  // No room to record the owner, hold the read back
  assign read_stall = rsp_full && grant_cmd.read;
  assign bus_ready  = s_ready && !read_stall;

  // Granted command to the slave
  // Read hidden during a stall so the slave cannot take it
  assign s_address     = grant_cmd.address;
  assign s_writedata   = grant_cmd.writedata;
  assign s_read        = grant_cmd.read && !rsp_full;
  assign s_write       = grant_cmd.write;
  assign s_burstcount  = grant_cmd.burst_count;
  assign s_begin_burst = grant_cmd.begin_burst_transfer;

  // Read data shared, valid steered per master
  assign m_readdata = s_readdata;

  avl_bus_rsp_route #(
    .MASTER_NUM(MASTER_NUM)
  ) rsp_route_inst (
    .clk              (clk),
    .rest             (rest),
    .push             (bus_ready && grant_cmd.read),
    .owner            (sel),
    .pop              (s_readdatavalid),
    .full             (rsp_full),
    .readdatavalid_out(m_readdatavalid)
  );

endmodule

// ==== tb/avl_bus_slave_model.sv ====
`timescale 1ns/1ps

module avl_bus_slave_model (
  input  logic                           clk,
  input  logic                           rest,
  // Ready forced low when clear
  input  logic                           ready_en,
  // Random ready gaps when set
  input  logic                           rand_en,
  input  logic [avl_bus_pkg::ADDR_W-1:0] s_address,
  input  logic                           s_read,
  output logic                           s_ready,
  output logic [avl_bus_pkg::DATA_W-1:0] s_readdata,
  output logic                           s_readdatavalid
);

  // Read data is the address scrambled by this key
  localparam logic [31:0] RD_KEY = 32'h5a5a_a5a5;

  // Pending read words and the cycle each one is due
  logic [31:0] data_q [$];
  int          due_q [$];
  int          cyc;
  int          last_due;
  int          due;

  always @(posedge clk or negedge rest) begin
    if (!rest) begin
      s_ready         <= 1'b0;
      s_readdata      <= '0;
      s_readdatavalid <= 1'b0;
      cyc      = 0;
      last_due = 0;
      data_q.delete();
      due_q.delete();
    end else begin
      cyc = cyc + 1;
      // Accepted read, due 1 to 5 cycles later but never before an older one
      if (s_read && s_ready) begin
        due = cyc + 1 + int'($urandom % 5);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        data_q.push_back(s_address ^ RD_KEY);
        due_q.push_back(due);
      end
      // In-order return, one word per cycle
      s_readdatavalid <= 1'b0;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        s_readdatavalid <= 1'b1;
        s_readdata      <= data_q.pop_front();
        void'(due_q.pop_front());
      end
      // Roughly one cycle in four without ready in random mode
      s_ready <= ready_en && (!rand_en || ($urandom % 4 != 0));
    end
  end

endmodule

// ==== tb/avl_bus_nm21_tb.sv ====
`timescale 1ns/1ps

module avl_bus_nm21_tb #(
  parameter int ARB_METHOD = 0
);

  localparam int          NM      = 4;
  localparam logic [31:0] RD_KEY  = 32'h5a5a_a5a5;
  localparam int          TIMEOUT = 3000;

  logic                          clk;
  logic                          rest;
  logic [NM-1:0]                 m_request;
  logic [NM-1:0][31:0]           m_address;
  logic [NM-1:0][31:0]           m_writedata;
  logic [NM-1:0]                 m_read;
  logic [NM-1:0]                 m_write;
  logic [NM-1:0][3:0]            m_burstcount;
  logic [NM-1:0]                 m_begin_burst;
  logic [NM-1:0]                 m_ready;
  logic [31:0]                   m_readdata;
  logic [NM-1:0]                 m_readdatavalid;
  logic [31:0]                   s_address;
  logic [31:0]                   s_writedata;
  logic                          s_read;
  logic                          s_write;
  logic [3:0]                    s_burstcount;
  logic                          s_begin_burst;
  logic                          s_ready;
  logic [31:0]                   s_readdata;
  logic                          s_readdatavalid;
  logic                          ready_en;
  logic                          rand_en;

  // Commands waiting per master with the front one on the bus
  avl_bus_pkg::avl_cmd_t cmd_q [NM][$];
  logic [NM-1:0]         acc_flag;
  // Outstanding reads in issue order
  int                    rd_owner [$];
  logic [31:0]           rd_addr [$];
  int                    acc_log [$];
  int                    acc_cnt [NM];
  int                    ret_cnt;
  // Reference arbiter state
  int                    r_last;
  int                    r_lock;
  int                    r_lock_m;
  string                 cur_test;
  int                    errors;
  int                    test_err;
  int                    tests_failed;

  avl_bus_nm21 #(.ARB_METHOD(ARB_METHOD), .MASTER_NUM(NM)) avl_bus_nm21_inst (.*);

  avl_bus_slave_model slave_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Expected grant from request, last grant and lock
  function automatic int ref_sel(logic [NM-1:0] req, int last, int lock, int lock_m);
    int idx;
    if (lock != 0) return lock_m;
    if (req == '0) return last;
    for (int k = 1; k <= NM; k++) begin
      idx = (ARB_METHOD == 0) ? (last + k) % NM : k - 1;
      if (req[idx]) return idx;
    end
    return last;
  endfunction

  task automatic compare_value(string what, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  task automatic report_failure(string msg);
    $display("%s: %s", cur_test, msg);
    errors++;
  endtask

  // Master side drives 2 ns after the edge
  always @(posedge clk) begin
    #2;
    for (int i = 0; i < NM; i++) begin
      if (acc_flag[i]) begin
        void'(cmd_q[i].pop_front());
        acc_flag[i] = 1'b0;
      end
      if (cmd_q[i].size() > 0) begin
        m_request[i]     = 1'b1;
        m_address[i]     = cmd_q[i][0].address;
        m_writedata[i]   = cmd_q[i][0].writedata;
        m_read[i]        = cmd_q[i][0].read;
        m_write[i]       = cmd_q[i][0].write;
        m_burstcount[i]  = cmd_q[i][0].burst_count;
        m_begin_burst[i] = cmd_q[i][0].begin_burst_transfer;
      end else begin
        m_request[i]     = 1'b0;
        m_read[i]        = 1'b0;
        m_write[i]       = 1'b0;
        m_begin_burst[i] = 1'b0;
      end
    end
  end

  // Compare at the falling edge where everything has settled
  always @(negedge clk) begin
    int   es;
    logic full;
    logic rdy;
    if (rest) begin
      es   = ref_sel(m_request, r_last, r_lock, r_lock_m);
      full = rd_owner.size() >= avl_bus_pkg::RSP_FIFO_DEPTH;
      rdy  = s_ready && !(m_read[es] && full);
      compare_value("sel", es, avl_bus_nm21_inst.sel);
      compare_value("s_address", m_address[es], s_address);
      compare_value("s_writedata", m_writedata[es], s_writedata);
      compare_value("s_read", m_read[es] && !full, s_read);
      compare_value("s_write", m_write[es], s_write);
      compare_value("s_burstcount", m_burstcount[es], s_burstcount);
      compare_value("s_begin_burst", m_begin_burst[es], s_begin_burst);
      compare_value("m_ready", rdy ? (1 << es) : 0, m_ready);
      // Returned word goes to the oldest issuer
      if (s_readdatavalid) begin
        assert (rd_owner.size() != 0) else begin
          report_failure("read data returned with no read outstanding");
        end
        if (rd_owner.size() != 0) begin
          compare_value("m_readdatavalid", 1 << rd_owner[0], m_readdatavalid);
          compare_value("m_readdata", rd_addr[0] ^ RD_KEY, m_readdata);
          void'(rd_owner.pop_front());
          void'(rd_addr.pop_front());
          ret_cnt++;
        end
      end else begin
        compare_value("m_readdatavalid", 0, m_readdatavalid);
      end
      // Acceptance moves the reference state
      if (rdy && (m_read[es] || m_write[es])) begin
        acc_flag[es] = 1'b1;
        acc_cnt[es]++;
        acc_log.push_back(es);
        if (m_read[es]) begin
          rd_owner.push_back(es);
          rd_addr.push_back(m_address[es]);
        end
        if (r_lock != 0) begin
          r_lock--;
        end else if (m_begin_burst[es] && m_burstcount[es] != 0) begin
          r_lock   = m_burstcount[es] - 1;
          r_lock_m = es;
        end
        r_last = es;
      end
    end
  end

  task automatic add_cmd(int m, logic [31:0] addr, logic rd, int bc, logic first);
    avl_bus_pkg::avl_cmd_t c;
    c.address              = addr;
    c.writedata            = ~addr;
    c.read                 = rd;
    c.write                = !rd;
    c.burst_count          = 4'(bc);
    c.begin_burst_transfer = first;
    cmd_q[m].push_back(c);
  endtask

  // Write burst with the begin flag on the first beat only
  task automatic add_burst(int m, int len, logic [31:0] base);
    for (int b = 0; b < len; b++) begin
      add_cmd(m, base + 32'(4 * b), 1'b0, len, b == 0);
    end
  endtask

  task automatic start_test(string name);
    cur_test = name;
    test_err = errors;
    acc_log.delete();
    ret_cnt  = 0;
    for (int i = 0; i < NM; i++) acc_cnt[i] = 0;
  endtask

  task automatic end_test();
    if (errors != test_err) tests_failed++;
    $display("Test %s: %s, %0d errors", cur_test,
             (errors == test_err) ? "PASS" : "FAIL", errors - test_err);
  endtask

  // All commands taken and all reads returned
  task automatic wait_drain();
    int n;
    n = 0;
    while ((cmd_q[0].size() + cmd_q[1].size() + cmd_q[2].size() + cmd_q[3].size()
            + rd_owner.size()) != 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (n < TIMEOUT) else report_failure("timed out waiting for the bus to drain");
    repeat (2) @(posedge clk);
    #2;
  endtask

  // Block until master m has a beat accepted
  task automatic wait_accept(int m);
    int n;
    n = 0;
    while (acc_cnt[m] == 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    assert (n < TIMEOUT) else report_failure("timed out waiting for an accepted beat");
    #2;
  endtask

  initial begin
    int start;
    int p;
    int len;
    int total;
    int m;
    int kind;
    int exp_cnt [NM];
    int exp_rd;
    void'($urandom(32'had77));
    rest = 1'b0;
    ready_en = 1'b1;
    rand_en = 1'b0;
    m_request = '0;
    m_address = '0;
    m_writedata = '0;
    m_read = '0;
    m_write = '0;
    m_burstcount = '0;
    m_begin_burst = '0;
    acc_flag = '0;
    r_last = NM - 1;
    r_lock = 0;
    r_lock_m = 0;
    errors = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    #2 rest = 1'b1;

    start_test("single_master");
    add_cmd(2, 32'h0000_1000, 1'b0, 1, 1'b1);
    for (int k = 0; k < 3; k++) add_cmd(2, 32'h0000_2000 + 32'(k * 4), 1'b1, 1, 1'b1);
    wait_drain();
    compare_value("reads returned", 3, ret_cnt);
    compare_value("master 2 accepted", 4, acc_cnt[2]);
    end_test();

    start_test("arbitration_order");
    start = (r_last + 1) % NM;
    for (int i = 0; i < NM; i++) begin
      for (int k = 0; k < 4; k++) add_cmd(i, 32'(i * 256 + k * 4), 1'b0, 1, 1'b1);
    end
    wait_drain();
    compare_value("accepted count", 16, acc_log.size());
    for (int k = 0; k < acc_log.size(); k++) begin
      compare_value("grant order", (ARB_METHOD == 0) ? (start + k) % NM : k / 4, acc_log[k]);
    end
    end_test();

    start_test("burst_lock");
    rand_en = 1'b1;
    len = 1 + int'($urandom % avl_bus_pkg::BURST_MAX_COUNT);
    add_burst(1, len, 32'h0001_0000);
    for (int i = 2; i < NM; i++) begin
      for (int k = 0; k < 3; k++) begin
        add_cmd(i, 32'(i * 64 + k * 4), 1'b0, 1, 1'b1);
      end
    end
    // Master 0 asks only once the burst holds the bus
    wait_accept(1);
    for (int k = 0; k < 3; k++) begin
      add_cmd(0, 32'(k * 4), 1'b0, 1, 1'b1);
    end
    wait_drain();
    p = 0;
    while (p < acc_log.size() && acc_log[p] != 1) p++;
    assert (p + len <= acc_log.size()) else begin
      report_failure("burst beats missing from the log");
    end
    for (int k = p; k < p + len && k < acc_log.size(); k++) begin
      compare_value("burst owner", 1, acc_log[k]);
    end
    compare_value("burst beats", len, acc_cnt[1]);
    end_test();

    start_test("back_pressure");
    ready_en = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    total = acc_log.size();
    add_cmd(0, 32'h0000_3000, 1'b1, 1, 1'b1);
    add_cmd(3, 32'h0000_3100, 1'b0, 1, 1'b1);
    repeat (6) begin
      @(negedge clk);
      compare_value("m_ready while stalled", 0, m_ready);
    end
    compare_value("accepted while stalled", total, acc_log.size());
    @(posedge clk);
    #2 ready_en = 1'b1;
    wait_drain();
    compare_value("accepted after stall", 2, acc_log.size());
    end_test();

    start_test("response_routing");
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < NM; i++) add_cmd(i, 32'(32'h100 * (i + 1) + k * 4), 1'b1, 1, 1'b1);
    end
    wait_drain();
    compare_value("reads returned", 12, ret_cnt);
    end_test();

    start_test("random_mix");
    exp_rd = 0;
    for (int i = 0; i < NM; i++) exp_cnt[i] = 0;
    for (int n = 0; n < 80; n++) begin
      m    = int'($urandom % NM);
      kind = int'($urandom % 3);
      if (kind == 0) begin
        add_cmd(m, $urandom & 32'hffff_fffc, 1'b1, 1, 1'b1);
        exp_cnt[m]++;
        exp_rd++;
      end else begin
        len = (kind == 1) ? 1 : 1 + int'($urandom % avl_bus_pkg::BURST_MAX_COUNT);
        add_burst(m, len, $urandom & 32'hffff_ff00);
        exp_cnt[m] += len;
      end
    end
    wait_drain();
    for (int i = 0; i < NM; i++) compare_value("accepted per master", exp_cnt[i], acc_cnt[i]);
    compare_value("reads returned", exp_rd, ret_cnt);
    end_test();

    $display("Tests run 6, failed %0d, errors %0d", tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== avl_bus_nm21.f ====
hdl/avl_bus_pkg.sv
hdl/avl_bus_priority_encoder.sv
hdl/avl_bus_mux_n21.sv
hdl/avl_bus_nm21_arb.sv
hdl/avl_bus_rsp_route.sv
hdl/avl_bus_nm21.sv
tb/avl_bus_slave_model.sv
tb/avl_bus_nm21_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench once per arbitration method
set -e
cd "$(dirname "$0")"

for method in 0 1; do
  obj="obj_arb${method}"
  log="sim_arb${method}.log"
  verilator --binary --timing -Wall -Wno-fatal \
    --top-module avl_bus_nm21_tb \
    -GARB_METHOD=${method} \
    -Mdir "${obj}" \
    -f avl_bus_nm21.f
  "./${obj}/Vavl_bus_nm21_tb" > "${log}" 2>&1 || true
  cat "${log}"
  if ! grep -q "All tests passed" "${log}"; then
    echo "ARB_METHOD=${method} failed"
    exit 1
  fi
done
echo "Both arbitration methods passed"
